//--- Makefile
TOP  := tb_pcie_inb_wr
SRCS := $(filter-out +incdir+%,$(shell cat compile.f))

obj_dir/V$(TOP): compile.f $(SRCS) hw/pcie_inb_cfg.svh
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- compile.f
+incdir+hw
hw/axi_pkg.sv
hw/pcie_inb_pkg.sv
hw/sync_fifo.sv
hw/wr_cmd_split.sv
hw/inbound_write.sv
hw/axi_wr_ram.sv
hw/pcie_inb_wr_top.sv
dv/tb_clk_gen.sv
dv/inbound_write_checker.sv
dv/tb_pcie_inb_wr.sv

//--- dv/inbound_write_checker.sv
`include "pcie_inb_cfg.svh"

module inbound_write_checker
    import axi_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   axi_aw_valid,
    input logic                   axi_aw_ready,
    input logic [`INB_ADDR_W-1:0] axi_aw_addr,
    input logic [`INB_LEN_W-1:0]  axi_aw_len,
    input logic                   axi_w_valid,
    input logic                   axi_w_ready,
    input logic [31:0]            axi_w_data,
    input logic [3:0]             axi_w_strb,
    input logic                   axi_w_last,
    input logic                   cpl_h_valid,
    input logic                   cpl_h_ready,
    input axi_resp_t              cpl_h_resp,
    input logic                   err_valid,
    input logic                   err_ready,
    input logic                   err_unsupported
);

    int                    fail_cnt = 0;
    logic [12:0]           aw_end;
    logic [`INB_LEN_W-1:0] aw_len_q;
    logic [`INB_LEN_W:0]   w_beats;

    // Byte offset of the last beat, bit 12 set means the page was left
    assign aw_end = {1'b0, axi_aw_addr[11:0]} + {7'd0, axi_aw_len, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_len_q <= '0;
            w_beats  <= '0;
        end else begin
            if (axi_aw_valid && axi_aw_ready) begin
                aw_len_q <= axi_aw_len;
            end
            if (axi_w_valid && axi_w_ready) begin
                w_beats <= axi_w_last ? '0 : w_beats + 1'b1;
            end
        end
    end

    aw_no_4k_cross: assert property (@(posedge clk) disable iff (rst)
        axi_aw_valid |-> !aw_end[12])
    else begin
        $error("AW burst crosses a 4 KB boundary");
        fail_cnt = fail_cnt + 1;
    end

    // Beats actually sent on W, independent of the AW length field
    burst_max_len: assert property (@(posedge clk) disable iff (rst)
        axi_w_valid && axi_w_ready |-> (int'(w_beats) < 16))
    else begin
        $error("Burst longer than 16 beats");
        fail_cnt = fail_cnt + 1;
    end

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        axi_aw_valid && !axi_aw_ready |=>
            axi_aw_valid && $stable(axi_aw_addr) && $stable(axi_aw_len))
    else begin
        $error("AW valid or payload changed before the handshake");
        fail_cnt = fail_cnt + 1;
    end

    w_stable: assert property (@(posedge clk) disable iff (rst)
        axi_w_valid && !axi_w_ready |=> axi_w_valid && $stable(axi_w_data) &&
            $stable(axi_w_strb) && $stable(axi_w_last))
    else begin
        $error("W valid or payload changed before the handshake");
        fail_cnt = fail_cnt + 1;
    end

    cpl_stable: assert property (@(posedge clk) disable iff (rst)
        cpl_h_valid && !cpl_h_ready |=> cpl_h_valid && $stable(cpl_h_resp))
    else begin
        $error("Completion valid or response changed before the handshake");
        fail_cnt = fail_cnt + 1;
    end

    err_stable: assert property (@(posedge clk) disable iff (rst)
        err_valid && !err_ready |=> err_valid && $stable(err_unsupported))
    else begin
        $error("Error valid or flag changed before the handshake");
        fail_cnt = fail_cnt + 1;
    end

    // Beats counted from zero, so the last one sits at aw_len
    w_beat_count: assert property (@(posedge clk) disable iff (rst)
        axi_w_valid && axi_w_ready && axi_w_last |-> (w_beats == {1'b0, aw_len_q}))
    else begin
        $error("W beat count does not match the AW burst length");
        fail_cnt = fail_cnt + 1;
    end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !axi_aw_valid && !cpl_h_valid)
    else begin
        $error("AW or completion valid high right after reset");
        fail_cnt = fail_cnt + 1;
    end

endmodule

//--- dv/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

//--- dv/tb_pcie_inb_wr.sv
`include "pcie_inb_cfg.svh"

module tb_pcie_inb_wr
    import axi_pkg::*;
();

    localparam int RAM_WORDS = 1 << `INB_RAM_AW;
    localparam int TIMEOUT   = 4000;

    logic                   clk;
    logic                   rst;
    logic [`INB_TOKN-1:0]   token_wr;
    logic                   req_h_ready;
    logic                   req_h_valid;
    logic                   req_h_np;
    logic [`INB_ADDR_W-1:2] req_h_addr;
    logic [9:0]             req_h_len;
    logic [`INB_TOKN-1:0]   req_h_token;
    logic                   req_d_ready;
    logic                   req_d_valid;
    logic [31:0]            req_d_data;
    logic [3:0]             req_d_strb;
    logic                   cpl_h_ready;
    logic                   cpl_h_valid;
    axi_resp_t              cpl_h_resp;
    logic                   err_ready;
    logic                   err_valid;
    logic                   err_unsupported;
    logic                   wr_busy;
    logic                   wr_disable;
    logic                   wr_flush;
    logic [`INB_RAM_AW-1:0] mem_rd_addr;
    logic [31:0]            mem_rd_data;

    logic [31:0] shadow [RAM_WORDS];
    axi_resp_t   cpl_q [$];
    logic        err_q [$];
    int          seed;
    int          err_cnt;
    int          test_cnt;
    int          fail_tests;
    int          errs_at_start;
    bit          busy_seen;

    tb_clk_gen tb_clk_gen_i (.clk(clk));

    pcie_inb_wr_top pcie_inb_wr_top_i (.*);

    bind inbound_write inbound_write_checker inbound_write_checker_i (
        .clk(clk), .rst(rst),
        .axi_aw_valid(axi_aw_valid), .axi_aw_ready(axi_aw_ready),
        .axi_aw_addr(axi_aw_addr), .axi_aw_len(axi_aw_len),
        .axi_w_valid(axi_w_valid), .axi_w_ready(axi_w_ready),
        .axi_w_data(axi_w_data), .axi_w_strb(axi_w_strb), .axi_w_last(axi_w_last),
        .cpl_h_valid(cpl_h_valid), .cpl_h_ready(cpl_h_ready), .cpl_h_resp(cpl_h_resp),
        .err_valid(err_valid), .err_ready(err_ready), .err_unsupported(err_unsupported)
    );

    // Completion and error transfers in order of arrival
    always @(posedge clk) begin
        if (!rst && cpl_h_valid && cpl_h_ready) begin
            cpl_q.push_back(cpl_h_resp);
        end
        if (!rst && err_valid && err_ready) begin
            err_q.push_back(err_unsupported);
        end
    end

    function automatic int total_errors();
        return err_cnt + pcie_inb_wr_top_i.inbound_write_i.inbound_write_checker_i.fail_cnt;
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    task automatic expect_eq(string sig, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            $display("mismatch %s: got %h expected %h", sig, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_true(bit cond, string what);
        assert (cond) else begin
            $display("%s", what);
            err_cnt++;
        end
    endtask

    task automatic settle();
        repeat (8) @(negedge clk);
    endtask

    task automatic send_header(bit np, int addr, int len, logic [3:0] token);
        int t;
        t = 0;
        req_h_valid = 1'b1;
        req_h_np    = np;
        req_h_addr  = (`INB_ADDR_W - 2)'(addr);
        // 1024 dwords wraps to a length field of zero
        req_h_len   = 10'(len);
        req_h_token = token;
        while (!req_h_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        expect_true(req_h_ready, "timeout waiting for req_h_ready");
        @(negedge clk);
        req_h_valid = 1'b0;
    endtask

    task automatic send_beat(logic [31:0] d, logic [3:0] s);
        int t;
        t = 0;
        req_d_valid = 1'b1;
        req_d_data  = d;
        req_d_strb  = s;
        while (!req_d_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        expect_true(req_d_ready, "timeout waiting for req_d_ready");
        @(negedge clk);
        req_d_valid = 1'b0;
    endtask

    // Byte lanes with a strobe take the new data
    task automatic update_shadow(int a, logic [31:0] d, logic [3:0] s);
        int b;
        for (b = 0; b < 4; b++) begin
            if (s[b]) begin
                shadow[a][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic write_req(bit np, int addr, int len, logic [3:0] token, bit fill);
        int          i;
        int          a;
        logic [31:0] d;
        logic [3:0]  s;
        send_header(np, addr, len, token);
        for (i = 0; i < len; i++) begin
            a = addr + i;
            if (fill) begin
                d = fill_word(a);
                s = 4'hf;
            end else begin
                d = $random(seed);
                s = 4'($random(seed));
            end
            send_beat(d, s);
            if (a < RAM_WORDS) begin
                update_shadow(a, d, s);
            end
        end
    endtask

    // Splitter free and no burst outstanding
    task automatic wait_idle();
        int t;
        t = 0;
        while (!(req_h_ready && !wr_busy) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        expect_true(req_h_ready && !wr_busy, "timeout waiting for the write path to go idle");
    endtask

    task automatic wait_count(bit on_err, int n);
        int t;
        t = 0;
        while ((on_err ? err_q.size() : cpl_q.size()) < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        expect_true((on_err ? err_q.size() : cpl_q.size()) >= n,
                    on_err ? "timeout waiting for err_valid" : "timeout waiting for cpl_h_valid");
    endtask

    task automatic wait_err_valid();
        int t;
        t = 0;
        while (!err_valid && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        expect_true(err_valid, "timeout waiting for err_valid to rise");
    endtask

    // Read data shows up one cycle after the address
    task automatic check_range(int start, int n);
        int i;
        for (i = 0; i < n; i++) begin
            mem_rd_addr = `INB_RAM_AW'(start + i);
            @(negedge clk);
            expect_eq($sformatf("mem_rd_data[%03h]", start + i), mem_rd_data,
                      shadow[start + i]);
        end
    endtask

    task automatic check_cpls(int n, axi_resp_t resp);
        int i;
        expect_eq("completion count", cpl_q.size(), n);
        for (i = 0; i < cpl_q.size(); i++) begin
            expect_eq("cpl_h_resp", cpl_q[i], resp);
        end
    endtask

    task automatic start_test();
        cpl_q.delete();
        err_q.delete();
        errs_at_start = total_errors();
    endtask

    task automatic end_test(string name);
        int errs;
        errs = total_errors() - errs_at_start;
        test_cnt++;
        if (errs != 0) begin
            fail_tests++;
        end
        $display("test %0d %s: %s", test_cnt, name, (errs == 0) ? "ok" : "failed");
    endtask

    initial begin
        rst         = 1'b1;
        req_h_valid = 1'b0;
        req_h_np    = 1'b0;
        req_h_addr  = '0;
        req_h_len   = '0;
        req_h_token = '0;
        req_d_valid = 1'b0;
        req_d_data  = '0;
        req_d_strb  = '0;
        cpl_h_ready = 1'b1;
        err_ready   = 1'b1;
        wr_disable  = 1'b0;
        wr_flush    = 1'b0;
        mem_rd_addr = '0;
        seed        = 32'hc9b29ba7;
        err_cnt     = 0;
        test_cnt    = 0;
        fail_tests  = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Whole RAM gets a known pattern first
        start_test();
        write_req(1'b0, 0, 1024, 4'h1, 1'b1);
        write_req(1'b0, 1024, 1024, 4'h2, 1'b1);
        wait_idle();
        settle();
        expect_true(cpl_q.size() == 0 && err_q.size() == 0, "fill produced a completion or error");
        check_range(0, RAM_WORDS);
        end_test("ram fill");

        start_test();
        write_req(1'b0, 'h100, 12, 4'h3, 1'b0);
        wait_idle();
        settle();
        expect_true(cpl_q.size() == 0 && err_q.size() == 0,
                    "posted write produced a completion or error");
        check_range('h0fe, 16);
        end_test("posted write");

        start_test();
        write_req(1'b1, 'h200, 5, 4'h9, 1'b0);
        wait_count(1'b0, 1);
        wait_idle();
        settle();
        check_cpls(1, AXI_OKAY);
        expect_eq("token_wr", token_wr, 4'h9);
        check_range('h1ff, 7);
        end_test("non-posted write");

        start_test();
        write_req(1'b1, 'h3f8, 40, 4'h4, 1'b0);
        wait_count(1'b0, 1);
        wait_idle();
        settle();
        check_cpls(1, AXI_OKAY);
        expect_eq("token_wr", token_wr, 4'h4);
        check_range('h3f6, 44);
        end_test("4 KB crossing");

        start_test();
        err_ready = 1'b0;
        write_req(1'b0, 'h800, 4, 4'h5, 1'b0);
        wait_err_valid();
        // Error stays pending while err_ready is low
        repeat (3) @(negedge clk);
        err_ready = 1'b1;
        wait_count(1'b1, 1);
        if (err_q.size() > 0) begin
            expect_eq("err_unsupported", err_q[0], 1'b1);
        end
        write_req(1'b1, 'h810, 2, 4'h6, 1'b0);
        wait_count(1'b0, 1);
        wait_idle();
        settle();
        check_cpls(1, AXI_DECERR);
        expect_eq("error count", err_q.size(), 1);
        check_range(0, 32);
        end_test("out of range");

        start_test();
        wr_disable = 1'b1;
        write_req(1'b1, 'h300, 6, 4'h7, 1'b0);
        busy_seen = 1'b0;
        repeat (30) begin
            @(negedge clk);
            busy_seen = busy_seen | wr_busy;
        end
        expect_true(!busy_seen, "burst issued while wr_disable was high");
        expect_true(cpl_q.size() == 0, "completion appeared while wr_disable was high");
        wr_disable = 1'b0;
        wait_count(1'b0, 1);
        wait_idle();
        settle();
        check_cpls(1, AXI_OKAY);
        check_range('h300, 6);
        end_test("wr_disable");

        start_test();
        cpl_h_ready = 1'b0;
        write_req(1'b1, 'h310, 3, 4'h8, 1'b0);
        write_req(1'b1, 'h320, 3, 4'h9, 1'b0);
        write_req(1'b1, 'h330, 3, 4'ha, 1'b0);
        wait_idle();
        settle();
        expect_true(cpl_q.size() == 0, "completion transferred while cpl_h_ready was low");
        expect_true(cpl_h_valid, "no completion held while cpl_h_ready was low");
        cpl_h_ready = 1'b1;
        wait_count(1'b0, 3);
        settle();
        check_cpls(3, AXI_OKAY);
        expect_eq("token_wr", token_wr, 4'ha);
        check_range('h310, 48);
        end_test("completion back-pressure");

        start_test();
        wr_flush = 1'b1;
        write_req(1'b1, 'h500, 7, 4'hb, 1'b0);
        write_req(1'b1, 'h520, 20, 4'hc, 1'b0);
        wait_idle();
        settle();
        expect_true(cpl_q.size() == 0 && !cpl_h_valid, "completion appeared during wr_flush");
        expect_true(!wr_busy, "wr_busy still high after flushed writes");
        expect_eq("token_wr", token_wr, 4'hc);
        wr_flush = 1'b0;
        check_range('h500, 56);
        end_test("wr_flush");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_tests, total_errors());
        if (total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hw/axi_pkg.sv
package axi_pkg;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t AXI_OKAY   = 2'b00;
    localparam axi_resp_t AXI_SLVERR = 2'b10;
    localparam axi_resp_t AXI_DECERR = 2'b11;

endpackage

//--- hw/axi_wr_ram.sv
`include "pcie_inb_cfg.svh"

module axi_wr_ram
    import axi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   axi_aw_valid,
    output logic                   axi_aw_ready,
    input  logic [`INB_ADDR_W-1:0] axi_aw_addr,
    input  logic [`INB_LEN_W-1:0]  axi_aw_len,
    input  logic                   axi_w_valid,
    output logic                   axi_w_ready,
    input  logic [31:0]            axi_w_data,
    input  logic [3:0]             axi_w_strb,
    input  logic                   axi_w_last,
    output logic                   axi_b_valid,
    input  logic                   axi_b_ready,
    output axi_resp_t              axi_b_resp,
    input  logic [`INB_RAM_AW-1:0] mem_rd_addr,
    output logic [31:0]            mem_rd_data
);

    logic [31:0]            mem [1 << `INB_RAM_AW];
    logic                   active;
    logic                   in_range;
    logic                   bad_last;
    logic [`INB_RAM_AW-1:0] waddr;
    logic [`INB_LEN_W-1:0]  beat;
    logic [`INB_LEN_W-1:0]  len;
    logic                   w_fire;

    assign axi_aw_ready = !active;
    assign axi_w_ready  = active && !axi_b_valid;
    assign w_fire       = axi_w_valid && axi_w_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            axi_b_valid <= 1'b0;
        end else begin
            if (axi_aw_valid && axi_aw_ready) begin
                active <= 1'b1;
            end else if (axi_b_valid && axi_b_ready) begin
                active <= 1'b0;
            end
            if (w_fire && axi_w_last) begin
                axi_b_valid <= 1'b1;
            end else if (axi_b_ready) begin
                axi_b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (axi_aw_valid && axi_aw_ready) begin
            waddr    <= axi_aw_addr[`INB_RAM_AW+1:2];
            in_range <= (axi_aw_addr[`INB_ADDR_W-1:`INB_RAM_AW+2] == '0);
            len      <= axi_aw_len;
            beat     <= '0;
            bad_last <= 1'b0;
        end else if (w_fire) begin
            waddr <= waddr + 1'b1;
            beat  <= beat + 1'b1;
            // Last flag out of step with the burst length
            if (axi_w_last != (beat == len)) begin
                bad_last <= 1'b1;
            end
        end
    end

    always_comb begin
        if (!in_range) begin
            axi_b_resp = AXI_DECERR;
        end else if (bad_last) begin
            axi_b_resp = AXI_SLVERR;
        end else begin
            axi_b_resp = AXI_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (w_fire && in_range && axi_w_strb[i]) begin
                mem[waddr][8*i +: 8] <= axi_w_data[8*i +: 8];
            end
        end
        mem_rd_data <= mem[mem_rd_addr];
    end

endmodule

//--- hw/inbound_write.sv
`include "pcie_inb_cfg.svh"

module inbound_write
    import axi_pkg::*;
    import pcie_inb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic [`INB_TOKN-1:0]   token_wr,
    output logic                   req_h_ready,
    input  logic                   req_h_valid,
    input  logic                   req_h_np,
    input  logic [`INB_ADDR_W-1:2] req_h_addr,
    input  logic [9:0]             req_h_len,
    input  logic [`INB_TOKN-1:0]   req_h_token,
    output logic                   req_d_ready,
    input  logic                   req_d_valid,
    input  logic [31:0]            req_d_data,
    input  logic [3:0]             req_d_strb,
    input  logic                   cpl_h_ready,
    output logic                   cpl_h_valid,
    output axi_resp_t              cpl_h_resp,
    input  logic                   err_ready,
    output logic                   err_valid,
    output logic                   err_unsupported,
    input  logic                   axi_aw_ready,
    output logic                   axi_aw_valid,
    output logic [`INB_ADDR_W-1:0] axi_aw_addr,
    output logic [`INB_LEN_W-1:0]  axi_aw_len,
    input  logic                   axi_w_ready,
    output logic                   axi_w_valid,
    output logic [31:0]            axi_w_data,
    output logic [3:0]             axi_w_strb,
    output logic                   axi_w_last,
    output logic                   axi_b_ready,
    input  logic                   axi_b_valid,
    input  axi_resp_t              axi_b_resp,
    output logic                   wr_busy,
    input  logic                   wr_disable,
    input  logic                   wr_flush
);

    wr_beat_t               w_in;
    wr_beat_t               w_out;
    logic                   w_full;
    logic                   w_pop;
    logic [`INB_BUFA:0]     w_cnt;

    logic                   cmd_ready;
    logic                   cmd_valid;
    logic                   cmd_np;
    logic [`INB_ADDR_W-1:2] cmd_addr;
    logic [`INB_LEN_W:0]    cmd_len;
    logic [`INB_TOKN-1:0]   cmd_token;
    logic                   cmd_last;

    b_track_t               b_in;
    b_track_t               b_out;
    logic                   b_push;
    logic                   b_pop;
    logic                   b_full;
    logic                   b_empty;

    cpl_entry_t             ch_in;
    cpl_entry_t             ch_out;
    logic                   ch_push;
    logic                   ch_pop;
    logic                   ch_empty;
    logic                   ch_almost_full;

    axi_resp_t              resp;
    axi_resp_t              resp_accum;

    logic                   data_first;
    logic [`INB_LEN_W:0]    data_cnt;
    logic                   data_last;
    logic                   cmd_okay;

    assign req_d_ready = !w_full;
    assign w_in        = '{strb: req_d_strb, data: req_d_data};

    sync_fifo #(.T(wr_beat_t), .DEPTH(1 << `INB_BUFA)) w_fifo_i (
        .clk(clk), .rst(rst),
        .push(req_d_valid && req_d_ready), .wr_data(w_in), .pop(w_pop),
        .rd_data(w_out), .full(w_full), .empty(), .almost_full(), .count(w_cnt)
    );

    wr_cmd_split wr_cmd_split_i (
        .clk(clk), .rst(rst),
        .in_valid(req_h_valid), .in_np(req_h_np), .in_addr(req_h_addr),
        .in_len(req_h_len), .in_token(req_h_token), .out_ready(cmd_ready),
        .in_ready(req_h_ready), .out_valid(cmd_valid), .out_np(cmd_np),
        .out_addr(cmd_addr), .out_len(cmd_len), .out_token(cmd_token),
        .out_last(cmd_last)
    );

    // Expected responses, one per burst in flight
    assign b_in    = '{np: cmd_np, token: cmd_token, last: cmd_last};
    assign b_pop   = axi_b_valid && axi_b_ready;
    assign wr_busy = !b_empty;

    sync_fifo #(.T(b_track_t), .DEPTH(`INB_MOT)) b_fifo_i (
        .clk(clk), .rst(rst),
        .push(b_push), .wr_data(b_in), .pop(b_pop),
        .rd_data(b_out), .full(b_full), .empty(b_empty), .almost_full(), .count()
    );

    // First error of a request wins
    assign resp_accum = (resp != AXI_OKAY) ? resp : axi_b_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp     <= AXI_OKAY;
            token_wr <= '0;
        end else if (b_pop) begin
            resp <= b_out.last ? AXI_OKAY : resp_accum;
            if (b_out.last) begin
                token_wr <= b_out.token;
            end
        end
    end

    assign ch_push = b_pop && b_out.last && !wr_flush;
    assign ch_in   = '{np: b_out.np, resp: resp_accum};

    sync_fifo #(.T(cpl_entry_t), .DEPTH(4)) ch_fifo_i (
        .clk(clk), .rst(rst),
        .push(ch_push), .wr_data(ch_in), .pop(ch_pop),
        .rd_data(ch_out), .full(), .empty(ch_empty),
        .almost_full(ch_almost_full), .count()
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            axi_b_ready <= 1'b0;
        end else begin
            axi_b_ready <= !ch_almost_full || wr_flush;
        end
    end

    assign ch_pop = !ch_empty && !cpl_h_valid && !err_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cpl_h_valid <= 1'b0;
            err_valid   <= 1'b0;
        end else if (ch_pop) begin
            cpl_h_valid <= ch_out.np;
            err_valid   <= !ch_out.np && (ch_out.resp != AXI_OKAY);
        end else begin
            if (cpl_h_ready) begin
                cpl_h_valid <= 1'b0;
            end
            if (err_ready) begin
                err_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ch_pop) begin
            cpl_h_resp      <= ch_out.resp;
            err_unsupported <= (ch_out.resp != AXI_OKAY);
        end
    end

    // Burst starts only with all of its beats already buffered
    assign data_last = (data_cnt == cmd_len);
    assign cmd_okay  = !wr_disable && cmd_valid && !b_full &&
                       (int'(cmd_len) <= int'(w_cnt));
    assign w_pop     = ((!axi_aw_valid && cmd_okay) || !data_first) &&
                       (!axi_w_valid || axi_w_ready);
    assign b_push    = w_pop && data_first;
    assign cmd_ready = w_pop && data_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_first <= 1'b1;
            data_cnt   <= (`INB_LEN_W + 1)'(1);
        end else if (w_pop) begin
            data_first <= data_last;
            data_cnt   <= data_last ? (`INB_LEN_W + 1)'(1) : data_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            axi_aw_valid <= 1'b0;
            axi_w_valid  <= 1'b0;
        end else begin
            if (b_push) begin
                axi_aw_valid <= 1'b1;
            end else if (axi_aw_ready) begin
                axi_aw_valid <= 1'b0;
            end
            if (w_pop) begin
                axi_w_valid <= 1'b1;
            end else if (axi_w_ready) begin
                axi_w_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (b_push) begin
            axi_aw_addr <= {cmd_addr, 2'b00};
            axi_aw_len  <= cmd_len[`INB_LEN_W-1:0] - 1'b1;
        end
        if (w_pop) begin
            axi_w_data <= w_out.data;
            axi_w_strb <= w_out.strb;
            axi_w_last <= data_last;
        end
    end

endmodule

//--- hw/pcie_inb_cfg.svh
`ifndef PCIE_INB_CFG_SVH
`define PCIE_INB_CFG_SVH

// Byte address width of the AXI side
`define INB_ADDR_W 32
// AXI burst length field, up to 16 beats
`define INB_LEN_W 4
// Data buffer holds 2**INB_BUFA beats
`define INB_BUFA 6
// Outstanding bursts
`define INB_MOT 8
`define INB_TOKN 4
// RAM holds 2**INB_RAM_AW words
`define INB_RAM_AW 11

`endif

//--- hw/pcie_inb_pkg.sv
`include "pcie_inb_cfg.svh"

package pcie_inb_pkg;

    typedef struct packed {
        logic [3:0]  strb;
        logic [31:0] data;
    } wr_beat_t;

    // One entry per issued burst
    typedef struct packed {
        logic                np;
        logic [`INB_TOKN-1:0] token;
        logic                last;
    } b_track_t;

    typedef struct packed {
        logic               np;
        axi_pkg::axi_resp_t resp;
    } cpl_entry_t;

endpackage

//--- hw/pcie_inb_wr_top.sv
`include "pcie_inb_cfg.svh"

module pcie_inb_wr_top
    import axi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic [`INB_TOKN-1:0]   token_wr,
    output logic                   req_h_ready,
    input  logic                   req_h_valid,
    input  logic                   req_h_np,
    input  logic [`INB_ADDR_W-1:2] req_h_addr,
    input  logic [9:0]             req_h_len,
    input  logic [`INB_TOKN-1:0]   req_h_token,
    output logic                   req_d_ready,
    input  logic                   req_d_valid,
    input  logic [31:0]            req_d_data,
    input  logic [3:0]             req_d_strb,
    input  logic                   cpl_h_ready,
    output logic                   cpl_h_valid,
    output axi_resp_t              cpl_h_resp,
    input  logic                   err_ready,
    output logic                   err_valid,
    output logic                   err_unsupported,
    output logic                   wr_busy,
    input  logic                   wr_disable,
    input  logic                   wr_flush,
    input  logic [`INB_RAM_AW-1:0] mem_rd_addr,
    output logic [31:0]            mem_rd_data
);

    logic                   axi_aw_valid;
    logic                   axi_aw_ready;
    logic [`INB_ADDR_W-1:0] axi_aw_addr;
    logic [`INB_LEN_W-1:0]  axi_aw_len;
    logic                   axi_w_valid;
    logic                   axi_w_ready;
    logic [31:0]            axi_w_data;
    logic [3:0]             axi_w_strb;
    logic                   axi_w_last;
    logic                   axi_b_valid;
    logic                   axi_b_ready;
    axi_resp_t              axi_b_resp;

    inbound_write inbound_write_i (.*);

    axi_wr_ram axi_wr_ram_i (
        .clk(clk), .rst(rst),
        .axi_aw_valid(axi_aw_valid), .axi_aw_ready(axi_aw_ready),
        .axi_aw_addr(axi_aw_addr), .axi_aw_len(axi_aw_len),
        .axi_w_valid(axi_w_valid), .axi_w_ready(axi_w_ready),
        .axi_w_data(axi_w_data), .axi_w_strb(axi_w_strb), .axi_w_last(axi_w_last),
        .axi_b_valid(axi_b_valid), .axi_b_ready(axi_b_ready), .axi_b_resp(axi_b_resp),
        .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
    );

endmodule

//--- hw/sync_fifo.sv
module sync_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  T                           wr_data,
    input  logic                       pop,
    output T                           rd_data,
    output logic                       full,
    output logic                       empty,
    output logic                       almost_full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T           mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic       do_push;
    logic       do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry is visible without a pop
    assign rd_data     = mem[rd_ptr];
    assign full        = (count == DEPTH);
    assign empty       = (count == 0);
    assign almost_full = (count >= DEPTH - 1);

endmodule

//--- hw/wr_cmd_split.sv
`include "pcie_inb_cfg.svh"

module wr_cmd_split (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic                     in_np,
    input  logic [`INB_ADDR_W-1:2]   in_addr,
    input  logic [9:0]               in_len,
    input  logic [`INB_TOKN-1:0]     in_token,
    input  logic                     out_ready,
    output logic                     in_ready,
    output logic                     out_valid,
    output logic                     out_np,
    output logic [`INB_ADDR_W-1:2]   out_addr,
    output logic [`INB_LEN_W:0]      out_len,
    output logic [`INB_TOKN-1:0]     out_token,
    output logic                     out_last
);

    // Largest piece in dwords, capped at half the data buffer
    localparam int MAX_DW = ((1 << `INB_LEN_W) > (1 << (`INB_BUFA - 1))) ?
                            (1 << (`INB_BUFA - 1)) : (1 << `INB_LEN_W);

    logic        held;
    logic [10:0] rem;
    logic [10:0] to_4k;
    logic [10:0] piece;

    assign in_ready  = !held;
    assign out_valid = held;

    always_comb begin
        to_4k = 11'd1024 - {1'b0, out_addr[11:2]};
        piece = rem;
        if (piece > to_4k) begin
            piece = to_4k;
        end
        if (piece > 11'(MAX_DW)) begin
            piece = 11'(MAX_DW);
        end
    end

    assign out_len  = piece[`INB_LEN_W:0];
    assign out_last = (rem == piece);

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (in_valid && in_ready) begin
            held <= 1'b1;
        end else if (out_valid && out_ready && out_last) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_np    <= in_np;
            out_token <= in_token;
            out_addr  <= in_addr;
            // Length field of zero means 1024 dwords
            rem       <= {(in_len == 10'd0), in_len};
        end else if (out_valid && out_ready) begin
            out_addr  <= out_addr + (`INB_ADDR_W - 2)'(piece);
            rem       <= rem - piece;
        end
    end

endmodule
